//--- build.f
hdl/gopigo_pkg.sv
hdl/spi_byte_master.sv
hdl/cmd_watch.sv
hdl/frame_sequencer.sv
hdl/gopigo_spi_top.sv
tb/gopigo_slave_model.sv
tb/tb_gopigo_spi.sv

//--- Makefile
TOP = tb_gopigo_spi

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

//--- tb/tb_gopigo_spi.sv
`timescale 1ns/10ps

module tb_gopigo_spi import gopigo_pkg::*; ();

  localparam int half_cycles  = 6;      // 125 MHz clock with 10 MHz sclk
  localparam int wait_limit   = 20000;  // cycles
  localparam int quiet_cycles = 1200;   // longer than an 8 byte frame

  typedef struct packed {
    spi_byte_t   pwm_l;
    spi_byte_t   pwm_r;
    logic [15:0] dps_lim;
    logic [15:0] dps_l;
    logic [15:0] dps_r;
    logic [23:0] eye_l;
    logic [23:0] eye_r;
  } set_vals_t;

  // frame ids 0 get l, 1 get r, 2 pwm l, 3 pwm r, 4 dps limit, 5 dps l, 6 dps r, 7 eye l, 8 eye r
  typedef struct packed {
    set_vals_t   vals;
    logic [1:0]  get;         // bit 0 left, bit 1 right
    logic        late_get;    // two pulses once the set frame is on the wire
    logic        bad_marker;
    logic [3:0]  exp_n;       // frames expected
    logic [35:0] exp_ids;     // ids in arrival order, nibble 0 first
  } row_t;

  logic      clk;
  logic      reset_i;
  set_vals_t port_vals;
  logic      get_l;
  logic      get_r;
  ticks_t    ticks_left;
  ticks_t    ticks_right;
  logic      rdy_l;
  logic      rdy_r;
  logic      t_err;
  logic      sclk;
  logic      mosi;
  logic      ss_n;
  logic      miso;
  logic      running;
  spi_byte_t reply_marker_q;
  ticks_t    reply_ticks_q;
  int        frame_cnt;

  row_t      rows [8];
  int        n_rows = 0;
  spi_byte_t exp_fb [8];
  int        exp_len;
  ticks_t    exp_tl;
  ticks_t    exp_tr;
  integer    seed;
  int        check_cnt = 0;
  int        err_cnt = 0;
  // bus monitor state
  int        rdy_l_cnt = 0;
  int        rdy_r_cnt = 0;
  int        err_pulse_cnt = 0;
  int        bus_err_cnt = 0;
  int        hi_cycles = 0;
  bit        seen_frame = 1'b0;

  gopigo_spi_top #(
    .clk_freq_mhz (125),
    .sclk_khz     (10000)
  ) u_dut (
    .clk                 (clk),
    .reset_i             (reset_i),
    .motor_pwm_left_i    (port_vals.pwm_l),
    .motor_pwm_right_i   (port_vals.pwm_r),
    .motor_dps_limit_i   (port_vals.dps_lim),
    .motor_dps_left_i    (port_vals.dps_l),
    .motor_dps_right_i   (port_vals.dps_r),
    .led_eye_left_rgb_i  (port_vals.eye_l),
    .led_eye_right_rgb_i (port_vals.eye_r),
    .get_ticks_left_i    (get_l),
    .get_ticks_right_i   (get_r),
    .ticks_left_o        (ticks_left),
    .ticks_right_o       (ticks_right),
    .ticks_left_rdy_o    (rdy_l),
    .ticks_right_rdy_o   (rdy_r),
    .ticks_err_o         (t_err),
    .sclk_o              (sclk),
    .mosi_o              (mosi),
    .spi_ss_n_o          (ss_n),
    .miso_i              (miso),
    .rpi_running_o       (running)
  );

  gopigo_slave_model u_slave (
    .sclk_i         (sclk),
    .mosi_i         (mosi),
    .ss_n_i         (ss_n),
    .miso_o         (miso),
    .reply_marker_i (reply_marker_q),
    .reply_ticks_i  (reply_ticks_q),
    .frame_cnt_o    (frame_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // pulse counts and bus rules sampled mid cycle
  always @(negedge clk) begin
    if (!reset_i) begin
      if (rdy_l) rdy_l_cnt++;
      if (rdy_r) rdy_r_cnt++;
      if (t_err) err_pulse_cnt++;
      if (ss_n && sclk) begin
        bus_err_cnt++;
        $display("sclk_o is high while spi_ss_n_o is high at %0t", $time);
      end
      if (ss_n) begin
        hi_cycles++;
      end else begin
        if (seen_frame && hi_cycles != 0 && hi_cycles < 2 * half_cycles) begin
          bus_err_cnt++;
          $display("gap between frames only %0d cycles at %0t", hi_cycles, $time);
        end
        hi_cycles  = 0;
        seen_frame = 1'b1;
      end
    end
  end

  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ticks(input string name, input ticks_t got, input ticks_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input set_vals_t v, input logic [1:0] get, input logic late,
                         input logic bad, input logic [3:0] n, input logic [35:0] ids);
    rows[n_rows] = '{vals: v, get: get, late_get: late, bad_marker: bad,
                     exp_n: n, exp_ids: ids};
    n_rows++;
  endtask

  task automatic fill_table();
    set_vals_t v;
    v = '{pwm_l: 8'h1e, pwm_r: 8'hec, dps_lim: 16'h01f4, dps_l: 16'h0168,
          dps_r: 16'hfe98, eye_l: 24'h102030, eye_r: 24'h0a0b0c};
    add_row(v, 2'b00, 1'b0, 1'b0, 4'd7, 36'h0_0876_5432);  // reset pushes every set value
    v.pwm_r = 8'h32;
    add_row(v, 2'b00, 1'b0, 1'b0, 4'd1, 36'h3);
    v.dps_lim = 16'h0258;
    v.eye_r   = 24'hff8000;
    add_row(v, 2'b00, 1'b0, 1'b0, 4'd2, 36'h84);           // two changes arrive in priority order
    add_row(v, 2'b01, 1'b0, 1'b0, 4'd1, 36'h0);
    add_row(v, 2'b10, 1'b0, 1'b0, 4'd1, 36'h1);
    add_row(v, 2'b01, 1'b0, 1'b1, 4'd1, 36'h0);            // wrong marker
    v.dps_l = 16'hff38;
    add_row(v, 2'b10, 1'b0, 1'b0, 4'd2, 36'h51);           // get goes ahead of the set
    v.eye_l = 24'h00ff40;
    add_row(v, 2'b01, 1'b1, 1'b0, 4'd2, 36'h07);           // two pulses merge
  endtask

  // expected bytes of one frame
  task automatic build_frame(input int id, input set_vals_t v);
    logic [15:0] dps;
    logic [23:0] rgb;
    exp_fb    = '{default: 8'h00};
    exp_fb[0] = gopigo_addr;
    case (id)
      0, 1: begin
        exp_len   = 8;
        exp_fb[1] = (id == 0) ? msg_get_enc_left : msg_get_enc_right;
      end
      2, 3: begin
        exp_len   = 4;
        exp_fb[1] = msg_set_pwm;
        exp_fb[2] = (id == 2) ? port_mask_left : port_mask_right;
        exp_fb[3] = (id == 2) ? v.pwm_l : v.pwm_r;
      end
      4: begin
        exp_len   = 6;
        exp_fb[1] = msg_set_dps_limit;
        exp_fb[2] = port_mask_left | port_mask_right;  // both motors with power byte left at 0
        exp_fb[4] = v.dps_lim[15:8];
        exp_fb[5] = v.dps_lim[7:0];
      end
      5, 6: begin
        dps       = (id == 5) ? v.dps_l : v.dps_r;
        exp_len   = 5;
        exp_fb[1] = msg_set_dps;
        exp_fb[2] = (id == 5) ? port_mask_left : port_mask_right;
        exp_fb[3] = dps[15:8];
        exp_fb[4] = dps[7:0];
      end
      default: begin
        rgb       = (id == 7) ? v.eye_l : v.eye_r;
        exp_len   = 6;
        exp_fb[1] = msg_set_led;
        exp_fb[2] = (id == 7) ? led_eye_left : led_eye_right;
        exp_fb[3] = rgb[23:16];
        exp_fb[4] = rgb[15:8];
        exp_fb[5] = rgb[7:0];
      end
    endcase
  endtask

  task automatic check_frame(input int fi, input int id, input set_vals_t v);
    int start;
    int got_len;
    build_frame(id, v);
    start   = u_slave.rec_start[fi];
    got_len = u_slave.rec_len[fi];
    check_byte($sformatf("frame %0d length", fi), spi_byte_t'(got_len), spi_byte_t'(exp_len));
    for (int b = 0; b < exp_len; b++)
      check_byte($sformatf("mosi frame %0d byte %0d", fi, b), u_slave.rec_byte[start + b],
                 exp_fb[b]);
  endtask

  task automatic run_row(input int r, output bit ok);
    row_t row;
    int   base;
    int   l0;
    int   r0;
    int   e0;
    int   n;
    row  = rows[r];
    base = frame_cnt;
    l0   = rdy_l_cnt;
    r0   = rdy_r_cnt;
    e0   = err_pulse_cnt;
    ok   = 1'b1;
    reply_ticks_q  = $random(seed);
    reply_marker_q = row.bad_marker ? ~reply_marker : reply_marker;
    @(negedge clk);
    port_vals = row.vals;
    if (!row.late_get) begin
      {get_r, get_l} = row.get;
      @(negedge clk);
      {get_r, get_l} = 2'b00;
    end else begin
      n = 0;
      while (ss_n && n < wait_limit) begin  // set frame starts first
        @(negedge clk);
        n++;
      end
      if (ss_n) begin
        $display("timeout: row %0d, slave select never fell", r);
        ok = 1'b0;
        return;
      end
      repeat (2) begin
        @(negedge clk);
        {get_r, get_l} = row.get;
        @(negedge clk);
        {get_r, get_l} = 2'b00;
      end
    end
    n = 0;
    while (frame_cnt < base + int'(row.exp_n) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (frame_cnt < base + int'(row.exp_n)) begin
      $display("timeout: row %0d expected %0d frames, saw %0d", r, row.exp_n, frame_cnt - base);
      ok = 1'b0;
      return;
    end
    repeat (quiet_cycles) @(negedge clk);  // nothing more may arrive
    check_byte($sformatf("row %0d frame count", r), spi_byte_t'(frame_cnt - base),
               spi_byte_t'(row.exp_n));
    for (int k = 0; k < int'(row.exp_n); k++)
      check_frame(base + k, int'(row.exp_ids[4*k +: 4]), row.vals);
    if (row.get[0] && !row.bad_marker) exp_tl = reply_ticks_q;
    if (row.get[1] && !row.bad_marker) exp_tr = reply_ticks_q;
    check_flag("ticks_left_rdy_o", rdy_l_cnt != l0, row.get[0] & ~row.bad_marker);
    check_flag("ticks_right_rdy_o", rdy_r_cnt != r0, row.get[1] & ~row.bad_marker);
    check_flag("ticks_err_o", err_pulse_cnt != e0, (|row.get) & row.bad_marker);
    check_ticks("ticks_left_o", ticks_left, exp_tl);
    check_ticks("ticks_right_o", ticks_right, exp_tr);
  endtask

  task automatic report_counts();
    $display("checks %0d, compare errors %0d, bus errors %0d", check_cnt, err_cnt, bus_err_cnt);
  endtask

  initial begin
    bit ok;
    seed = 32'hbfed_8e00;
    fill_table();
    port_vals      = rows[0].vals;
    get_l          = 1'b0;
    get_r          = 1'b0;
    reset_i        = 1'b1;
    reply_marker_q = reply_marker;
    reply_ticks_q  = '0;
    exp_tl         = '0;
    exp_tr         = '0;
    ok             = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    // outputs in reset
    check_flag("spi_ss_n_o", ss_n, 1'b1);
    check_flag("sclk_o", sclk, 1'b0);
    check_flag("ticks_left_rdy_o", rdy_l, 1'b0);
    check_flag("ticks_right_rdy_o", rdy_r, 1'b0);
    check_flag("ticks_err_o", t_err, 1'b0);
    check_flag("rpi_running_o", running, 1'b0);
    check_ticks("ticks_left_o", ticks_left, '0);
    check_ticks("ticks_right_o", ticks_right, '0);
    reset_i = 1'b0;
    @(negedge clk);
    check_flag("rpi_running_o", running, 1'b1);
    for (int r = 0; r < n_rows && ok; r++)
      run_row(r, ok);  // a timeout ends the loop
    report_counts();
    if (ok && err_cnt == 0 && bus_err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- tb/gopigo_slave_model.sv
`timescale 1ns/10ps

module gopigo_slave_model import gopigo_pkg::*; (
  input  logic      sclk_i,
  input  logic      mosi_i,
  input  logic      ss_n_i,
  output logic      miso_o,
  input  spi_byte_t reply_marker_i,  // byte 3 of a read reply
  input  ticks_t    reply_ticks_i,   // bytes 4 to 7, msb first
  output int        frame_cnt_o      // frames completed so far
);

  spi_byte_t rec_byte  [256];  // every received byte, frames back to back
  int        rec_start [64];   // first byte of each frame in rec_byte
  int        rec_len   [64];   // bytes per frame
  int        byte_ptr;
  int        bit_cnt;          // bits clocked in the current frame
  spi_byte_t sh;
  logic      get_frame;        // type byte asked for encoder ticks

  // reply bit n of the frame, counted from the first msb
  function automatic logic reply_bit(int n);
    spi_byte_t b;
    b = 8'h00;
    if (get_frame) begin
      case (n / 8)
        3:       b = reply_marker_i;
        4:       b = reply_ticks_i[31:24];
        5:       b = reply_ticks_i[23:16];
        6:       b = reply_ticks_i[15:8];
        7:       b = reply_ticks_i[7:0];
        default: b = 8'h00;
      endcase
    end
    return b[7 - n % 8];
  endfunction

  initial begin
    miso_o      = 1'b0;
    frame_cnt_o = 0;
    byte_ptr    = 0;
    bit_cnt     = 0;
    get_frame   = 1'b0;
    sh          = 8'h00;
    forever begin
      @(negedge ss_n_i);
      bit_cnt   = 0;
      get_frame = 1'b0;
      rec_start[frame_cnt_o] = byte_ptr;
      miso_o = reply_bit(0);  // first bit ready before the first rising edge
      while (!ss_n_i) begin
        @(sclk_i or ss_n_i);
        if (!ss_n_i && sclk_i) begin
          sh = {sh[6:0], mosi_i};  // rising edge, mosi settled since the last fall
          bit_cnt++;
          if (bit_cnt % 8 == 0) begin
            rec_byte[byte_ptr] = sh;
            byte_ptr++;
          end
          if (bit_cnt == 16)
            get_frame = (sh == msg_get_enc_left) || (sh == msg_get_enc_right);
        end else if (!ss_n_i) begin
          miso_o = reply_bit(bit_cnt);  // falling edge moves to the next bit
        end
      end
      rec_len[frame_cnt_o] = byte_ptr - rec_start[frame_cnt_o];
      frame_cnt_o++;
      miso_o = 1'b0;
    end
  end

endmodule

//--- hdl/gopigo_spi_top.sv
`timescale 1ns/10ps

module gopigo_spi_top import gopigo_pkg::*; #(
  parameter int clk_freq_mhz = 12,   // use the pll output frequency if there is one
  parameter int sclk_khz     = 500
) (
  input  logic        clk,
  input  logic        reset_i,
  input  spi_byte_t   motor_pwm_left_i,
  input  spi_byte_t   motor_pwm_right_i,
  input  logic [15:0] motor_dps_limit_i,
  input  logic [15:0] motor_dps_left_i,
  input  logic [15:0] motor_dps_right_i,
  input  logic [23:0] led_eye_left_rgb_i,
  input  logic [23:0] led_eye_right_rgb_i,
  input  logic        get_ticks_left_i,
  input  logic        get_ticks_right_i,
  output ticks_t      ticks_left_o,
  output ticks_t      ticks_right_o,
  output logic        ticks_left_rdy_o,
  output logic        ticks_right_rdy_o,
  output logic        ticks_err_o,
  output logic        sclk_o,
  output logic        mosi_o,
  output logic        spi_ss_n_o,
  input  logic        miso_i,
  output logic        rpi_running_o   // tells the robot board the host side is up
);

  cmd_req_t  req;        // watcher to sequencer
  logic      req_valid;
  logic      req_ready;
  logic      spi_start;  // sequencer to byte master
  spi_byte_t spi_tx;
  spi_byte_t spi_rx;
  logic      spi_busy;
  logic      spi_done;

  assign rpi_running_o = ~reset_i;

  cmd_watch u_cmd_watch (
    .clk                 (clk),
    .reset_i             (reset_i),
    .motor_pwm_left_i    (motor_pwm_left_i),
    .motor_pwm_right_i   (motor_pwm_right_i),
    .motor_dps_limit_i   (motor_dps_limit_i),
    .motor_dps_left_i    (motor_dps_left_i),
    .motor_dps_right_i   (motor_dps_right_i),
    .led_eye_left_rgb_i  (led_eye_left_rgb_i),
    .led_eye_right_rgb_i (led_eye_right_rgb_i),
    .get_ticks_left_i    (get_ticks_left_i),
    .get_ticks_right_i   (get_ticks_right_i),
    .req_o               (req),
    .req_valid_o         (req_valid),
    .req_ready_i         (req_ready)
  );

  frame_sequencer u_frame_sequencer (
    .clk               (clk),
    .reset_i           (reset_i),
    .req_i             (req),
    .req_valid_i       (req_valid),
    .req_ready_o       (req_ready),
    .spi_start_o       (spi_start),
    .spi_tx_o          (spi_tx),
    .spi_busy_i        (spi_busy),
    .spi_done_i        (spi_done),
    .spi_rx_i          (spi_rx),
    .spi_ss_n_o        (spi_ss_n_o),
    .ticks_left_o      (ticks_left_o),
    .ticks_right_o     (ticks_right_o),
    .ticks_left_rdy_o  (ticks_left_rdy_o),
    .ticks_right_rdy_o (ticks_right_rdy_o),
    .ticks_err_o       (ticks_err_o)
  );

  spi_byte_master #(
    .clk_freq_mhz (clk_freq_mhz),
    .sclk_khz     (sclk_khz)
  ) u_spi_byte_master (
    .clk     (clk),
    .reset_i (reset_i),
    .start_i (spi_start),
    .tx_i    (spi_tx),
    .rx_o    (spi_rx),
    .busy_o  (spi_busy),
    .done_o  (spi_done),
    .sclk_o  (sclk_o),
    .mosi_o  (mosi_o),
    .miso_i  (miso_i)
  );

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer import gopigo_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  cmd_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output logic      spi_start_o,       // one cycle, only while master is idle
  output spi_byte_t spi_tx_o,
  input  logic      spi_busy_i,
  input  logic      spi_done_i,
  input  spi_byte_t spi_rx_i,
  output logic      spi_ss_n_o,        // active low, framed around the whole message
  output ticks_t    ticks_left_o,
  output ticks_t    ticks_right_o,
  output logic      ticks_left_rdy_o,
  output logic      ticks_right_rdy_o,
  output logic      ticks_err_o
);

  typedef enum logic [2:0] {
    st_idle,   // ready for a request
    st_setup,  // slave select just fell
    st_send,   // start the next byte once the master is free
    st_wait,   // byte in flight
    st_gap     // slave select high, master guard time
  } state_e;

  state_e      state_q;
  cmd_req_t    req_q;       // request being framed
  logic [2:0]  idx_q;       // byte index inside the frame
  logic        last_byte;
  logic        is_get;
  logic        accept;
  logic        marker_ok_q;
  logic [23:0] ticks_sh_q;  // upper three reply bytes, msb first
  ticks_t      ticks_new;
  spi_byte_t   msg_type;
  spi_byte_t   port_mask;

  assign req_ready_o = state_q == st_idle;
  assign accept      = req_valid_i & req_ready_o;
  assign spi_start_o = (state_q == st_send) & ~spi_busy_i;
  assign is_get      = req_q.kind == get_ticks;
  assign last_byte   = {1'b0, idx_q} == frame_len(req_q.kind) - 4'd1;
  assign ticks_new   = {ticks_sh_q, spi_rx_i};  // last byte goes straight in
  assign port_mask   = (req_q.port == port_right) ? port_mask_right : port_mask_left;

  always_comb begin
    case (req_q.kind)
      set_pwm:       msg_type = msg_set_pwm;
      set_dps_limit: msg_type = msg_set_dps_limit;
      set_dps:       msg_type = msg_set_dps;
      set_led_eye:   msg_type = msg_set_led;
      default:
        msg_type = (req_q.port == port_right) ? msg_get_enc_right : msg_get_enc_left;
    endcase
  end

  // byte on mosi for the current index
  always_comb begin
    spi_tx_o = 8'h00;  // gets clock out zeros after the type
    if (idx_q == 3'd0) begin
      spi_tx_o = gopigo_addr;
    end else if (idx_q == 3'd1) begin
      spi_tx_o = msg_type;
    end else begin
      case (req_q.kind)
        set_pwm: begin
          if (idx_q == 3'd2)
            spi_tx_o = port_mask;
          else
            spi_tx_o = req_q.payload[7:0];
        end
        set_dps: begin
          case (idx_q)
            3'd2:    spi_tx_o = port_mask;
            3'd3:    spi_tx_o = req_q.payload[15:8];
            default: spi_tx_o = req_q.payload[7:0];
          endcase
        end
        set_dps_limit: begin
          case (idx_q)
            3'd2:    spi_tx_o = port_mask_left | port_mask_right;  // both motors
            3'd3:    spi_tx_o = 8'h00;                           // power limit unused
            3'd4:    spi_tx_o = req_q.payload[15:8];
            default: spi_tx_o = req_q.payload[7:0];
          endcase
        end
        set_led_eye: begin
          case (idx_q)
            3'd2:    spi_tx_o = (req_q.port == port_right) ? led_eye_right : led_eye_left;
            3'd3:    spi_tx_o = req_q.payload[23:16];
            3'd4:    spi_tx_o = req_q.payload[15:8];
            default: spi_tx_o = req_q.payload[7:0];
          endcase
        end
        default: spi_tx_o = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      req_q <= req_i;
    if (state_q == st_wait && spi_done_i) begin
      if (idx_q == 3'd3)
        marker_ok_q <= spi_rx_i == reply_marker;
      ticks_sh_q <= {ticks_sh_q[15:0], spi_rx_i};  // extra early bytes fall off the top
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q           <= st_idle;
      idx_q             <= 3'd0;
      spi_ss_n_o        <= 1'b1;
      ticks_left_o      <= '0;
      ticks_right_o     <= '0;
      ticks_left_rdy_o  <= 1'b0;
      ticks_right_rdy_o <= 1'b0;
      ticks_err_o       <= 1'b0;
    end else begin
      ticks_left_rdy_o  <= 1'b0;  // pulses
      ticks_right_rdy_o <= 1'b0;
      ticks_err_o       <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q    <= st_setup;
            spi_ss_n_o <= 1'b0;
            idx_q      <= 3'd0;
          end
        end
        st_setup: state_q <= st_send;
        st_send: begin
          if (!spi_busy_i)
            state_q <= st_wait;  // start went out this cycle
        end
        st_wait: begin
          if (spi_done_i) begin
            idx_q <= idx_q + 3'd1;
            if (!last_byte) begin
              state_q <= st_send;
            end else begin
              state_q    <= st_gap;
              spi_ss_n_o <= 1'b1;
              if (is_get && marker_ok_q) begin
                if (req_q.port == port_right) begin
                  ticks_right_o     <= ticks_new;
                  ticks_right_rdy_o <= 1'b1;
                end else begin
                  ticks_left_o     <= ticks_new;
                  ticks_left_rdy_o <= 1'b1;
                end
              end else if (is_get) begin
                ticks_err_o <= 1'b1;  // bad marker, outputs keep old value
              end
            end
          end
        end
        st_gap: begin
          if (!spi_busy_i)
            state_q <= st_idle;  // master guard time is the frame gap
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

//--- hdl/cmd_watch.sv
`timescale 1ns/10ps

module cmd_watch import gopigo_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  spi_byte_t   motor_pwm_left_i,     // two's complement -100..100
  input  spi_byte_t   motor_pwm_right_i,
  input  logic [15:0] motor_dps_limit_i,    // 0 means no limit for either motor
  input  logic [15:0] motor_dps_left_i,
  input  logic [15:0] motor_dps_right_i,
  input  logic [23:0] led_eye_left_rgb_i,   // r[23:16] g[15:8] b[7:0]
  input  logic [23:0] led_eye_right_rgb_i,
  input  logic        get_ticks_left_i,     // one cycle pulse
  input  logic        get_ticks_right_i,
  output cmd_req_t    req_o,
  output logic        req_valid_o,
  input  logic        req_ready_i
);

  localparam int num_set = 7;            // pwm l/r, dps limit, dps l/r, eye l/r
  localparam int num_cmd = num_set + 2;  // plus the two gets in front

  logic [23:0]        port_val [num_set];  // set inputs widened to 24 bits in priority order
  logic [23:0]        shadow_q [num_set];  // inputs one cycle late
  logic [23:0]        sent_q   [num_set];  // value carried by the last accepted frame
  logic [num_cmd-1:0] pend_q;              // bit 0 get left ... bit 8 eye right
  logic [num_cmd-1:0] acc_vec;             // one hot of the accepted command
  logic [3:0]         sel;
  logic               accept;

  assign port_val[0] = {16'h0000, motor_pwm_left_i};
  assign port_val[1] = {16'h0000, motor_pwm_right_i};
  assign port_val[2] = {8'h00, motor_dps_limit_i};
  assign port_val[3] = {8'h00, motor_dps_left_i};
  assign port_val[4] = {8'h00, motor_dps_right_i};
  assign port_val[5] = led_eye_left_rgb_i;
  assign port_val[6] = led_eye_right_rgb_i;

  assign accept  = req_valid_o & req_ready_i;
  assign acc_vec = accept ? (num_cmd'(1) << sel) : '0;

  always_ff @(posedge clk) begin
    for (int j = 0; j < num_set; j++) begin
      shadow_q[j] <= port_val[j];
      if (acc_vec[j+2])
        sent_q[j] <= shadow_q[j];  // what the frame carries
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pend_q <= {{num_set{1'b1}}, 2'b00};  // push every set value once after reset
    end else begin
      // gets merge while pending and a pulse on the accept cycle starts a new one
      pend_q[0] <= (pend_q[0] & ~acc_vec[0]) | get_ticks_left_i;
      pend_q[1] <= (pend_q[1] & ~acc_vec[1]) | get_ticks_right_i;
      for (int j = 0; j < num_set; j++) begin
        if (acc_vec[j+2])
          pend_q[j+2] <= port_val[j] != shadow_q[j];  // changed again while accepted
        else
          pend_q[j+2] <= pend_q[j+2] | (port_val[j] != sent_q[j]);
      end
    end
  end

  // lowest index wins
  always_comb begin
    sel = 4'd0;
    for (int i = num_cmd - 1; i >= 0; i--) begin
      if (pend_q[i])
        sel = 4'(i);
    end
  end

  assign req_valid_o = |pend_q;

  always_comb begin
    req_o = '0;  // gets carry no payload
    case (sel)
      4'd0, 4'd1: req_o.kind = get_ticks;
      4'd2, 4'd3: req_o.kind = set_pwm;
      4'd4:       req_o.kind = set_dps_limit;
      4'd5, 4'd6: req_o.kind = set_dps;
      default:    req_o.kind = set_led_eye;
    endcase
    case (sel)
      4'd1, 4'd3, 4'd6, 4'd8: req_o.port = port_right;
      default:                req_o.port = port_left;
    endcase
    if (sel >= 4'd2)
      req_o.payload = shadow_q[3'(sel - 4'd2)];  // latest seen value
  end

endmodule

//--- hdl/spi_byte_master.sv
`timescale 1ns/10ps

module spi_byte_master import gopigo_pkg::*; #(
  parameter int clk_freq_mhz = 12,   // integer, rounded
  parameter int sclk_khz     = 500
) (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      start_i,   // one cycle with tx_i
  input  spi_byte_t tx_i,
  output spi_byte_t rx_o,      // valid with done_o
  output logic      busy_o,
  output logic      done_o,
  output logic      sclk_o,    // mode 0, idles low
  output logic      mosi_o,
  input  logic      miso_i
);

  // clock cycles per sclk half period, rounded to nearest
  localparam int half_cnt     = (clk_freq_mhz * 1000 + sclk_khz) / (2 * sclk_khz);
  localparam int div_w        = (half_cnt > 1) ? $clog2(half_cnt) : 1;
  localparam int guard_halves = 2;  // sclk idle time after each byte

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_guard
  } state_e;

  state_e           state_q;
  logic [div_w-1:0] div_q;
  logic [3:0]       half_q;   // half periods done in this phase
  logic             tick;     // end of a half period
  logic             sclk_q;
  logic             done_q;
  spi_byte_t        tx_sh_q;
  spi_byte_t        rx_sh_q;

  assign tick   = div_q == div_w'(half_cnt - 1);
  assign busy_o = state_q != st_idle;
  assign done_o = done_q;
  assign sclk_o = sclk_q;
  assign mosi_o = tx_sh_q[7];  // msb first
  assign rx_o   = rx_sh_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= st_idle;
      div_q   <= '0;
      half_q  <= 4'd0;
      sclk_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // divider restarts with each byte so the first half period is full
      if (tick || state_q == st_idle)
        div_q <= '0;
      else
        div_q <= div_q + 1'b1;
      case (state_q)
        st_idle: begin
          if (start_i) begin
            state_q <= st_shift;
            half_q  <= 4'd0;
          end
        end
        st_shift: begin
          if (tick) begin
            sclk_q <= ~sclk_q;
            half_q <= half_q + 4'd1;
            if (half_q == 4'd15) begin  // 16th edge brings sclk back low
              state_q <= st_guard;
              half_q  <= 4'd0;
              done_q  <= 1'b1;
            end
          end
        end
        st_guard: begin
          if (tick) begin
            half_q <= half_q + 4'd1;
            if (half_q == 4'(guard_halves - 1))
              state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle && start_i) begin
      tx_sh_q <= tx_i;  // bit 7 on mosi before the first rising edge
    end else if (state_q == st_shift && tick) begin
      if (!sclk_q)
        rx_sh_q <= {rx_sh_q[6:0], miso_i};  // rising edge samples
      else
        tx_sh_q <= {tx_sh_q[6:0], 1'b0};    // falling edge moves to next bit
    end
  end

endmodule

//--- hdl/gopigo_pkg.sv
package gopigo_pkg;

  typedef logic [7:0]         spi_byte_t;  // one byte on the wire
  typedef logic signed [31:0] ticks_t;     // encoder count, two's complement

  // what a request asks the robot to do
  typedef enum logic [2:0] {
    get_ticks     = 3'd0,
    set_pwm       = 3'd1,
    set_dps_limit = 3'd2,
    set_dps       = 3'd3,
    set_led_eye   = 3'd4
  } cmd_kind_e;

  typedef enum logic {
    port_left  = 1'b0,
    port_right = 1'b1
  } port_e;

  typedef struct packed {
    cmd_kind_e   kind;
    port_e       port;     // ignored by dps limit, it covers both motors
    logic [23:0] payload;  // right aligned: pwm 8, dps 16, rgb 24 bits
  } cmd_req_t;

  localparam spi_byte_t gopigo_addr = 8'h08;  // first byte of every frame

  // message type bytes as the robot firmware numbers them
  localparam spi_byte_t msg_set_led       = 8'd6;
  localparam spi_byte_t msg_set_pwm       = 8'd10;
  localparam spi_byte_t msg_set_dps       = 8'd14;
  localparam spi_byte_t msg_set_dps_limit = 8'd15;
  localparam spi_byte_t msg_get_enc_left  = 8'd17;
  localparam spi_byte_t msg_get_enc_right = 8'd18;

  localparam spi_byte_t port_mask_left  = 8'h01;
  localparam spi_byte_t port_mask_right = 8'h02;

  localparam spi_byte_t led_eye_left  = 8'h02;
  localparam spi_byte_t led_eye_right = 8'h01;

  localparam spi_byte_t reply_marker = 8'hA5;  // slave puts it in byte 3 of a read

  // frame lengths in bytes, address and type included
  localparam logic [3:0] len_set_pwm       = 4'd4;
  localparam logic [3:0] len_set_dps       = 4'd5;
  localparam logic [3:0] len_set_dps_limit = 4'd6;
  localparam logic [3:0] len_set_led_eye   = 4'd6;
  localparam logic [3:0] len_get_ticks     = 4'd8;

  function automatic logic [3:0] frame_len(cmd_kind_e kind);
    case (kind)
      set_pwm:       frame_len = len_set_pwm;
      set_dps:       frame_len = len_set_dps;
      set_dps_limit: frame_len = len_set_dps_limit;
      set_led_eye:   frame_len = len_set_led_eye;
      default:       frame_len = len_get_ticks;
    endcase
  endfunction

endpackage
